//--- backend_defines.svh
`ifndef BACKEND_DEFINES_SVH
`define BACKEND_DEFINES_SVH

// datapath width
`define DATA_W     32

// physical register file
`define PRF_NUM_W  6
`define PRF_DEPTH  64

// issue queue entries
`define IQ_DEPTH   8

// immediate field that also holds the zero-extended source 2 number
`define IMM_W      16

`endif

//--- backend_pkg.sv
`default_nettype none

`include "backend_defines.svh"

package backend_pkg;

    typedef logic [`PRF_NUM_W-1:0] prf_num_t;

    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_or  = 3'd3,
        op_xor = 3'd4,
        op_slt = 3'd5,
        op_sll = 3'd6,
        op_srl = 3'd7
    } alu_op_e;

    // is_imm in the micro-op selects the reading
    typedef union packed {
        logic [`IMM_W-1:0]        prs2_ext;
        logic signed [`IMM_W-1:0] imm;
    } src2_u;

    typedef struct packed {
        alu_op_e  op;
        logic     is_imm;
        prf_num_t prs1;
        src2_u    src2;
        prf_num_t prd;
    } uop_t;

    // source 2 register number out of the zero-extended field
    function automatic prf_num_t src2_prs2(src2_u src2);
        return src2.prs2_ext[`PRF_NUM_W-1:0];
    endfunction

endpackage

`default_nettype wire

//--- dispatch_stage.sv
`default_nettype none

`include "backend_defines.svh"

module dispatch_stage import backend_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     flush_i,
    input  logic     valid0_i,
    input  logic     valid1_i,
    input  uop_t     uop0_i,
    input  uop_t     uop1_i,
    input  logic     ready_i,
    output logic     enq_valid0_o,
    output logic     enq_valid1_o,
    output uop_t     enq_uop0_o,
    output uop_t     enq_uop1_o,
    output logic     set_busy0_o,
    output logic     set_busy1_o,
    output prf_num_t set_num0_o,
    output prf_num_t set_num1_o
);

    logic valid0_q;
    logic valid1_q;
    uop_t uop0_q;
    uop_t uop1_q;

    // nothing is taken while the queue is short of room
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid0_q <= 1'b0;
            valid1_q <= 1'b0;
        end else if (flush_i) begin
            valid0_q <= 1'b0;
            valid1_q <= 1'b0;
        end else begin
            valid0_q <= valid0_i && ready_i;
            valid1_q <= valid1_i && ready_i;
        end
    end

    always_ff @(posedge clk) begin
        uop0_q <= uop0_i;
        uop1_q <= uop1_i;
    end

    assign enq_valid0_o = valid0_q;
    assign enq_valid1_o = valid1_q;
    assign enq_uop0_o   = uop0_q;
    assign enq_uop1_o   = uop1_q;

    // p0 is the constant zero register and never goes busy
    assign set_busy0_o  = valid0_q && (uop0_q.prd != '0);
    assign set_busy1_o  = valid1_q && (uop1_q.prd != '0);
    assign set_num0_o   = uop0_q.prd;
    assign set_num1_o   = uop1_q.prd;

endmodule

`default_nettype wire

//--- scoreboard.sv
`default_nettype none

`include "backend_defines.svh"

module scoreboard import backend_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       flush_i,
    input  logic                       set_busy0_i,
    input  logic                       set_busy1_i,
    input  prf_num_t                   set_num0_i,
    input  prf_num_t                   set_num1_i,
    input  logic                       clr_busy_i,
    input  prf_num_t                   clr_num_i,
    input  prf_num_t [`IQ_DEPTH-1:0]   rs1_nums_i,
    input  prf_num_t [`IQ_DEPTH-1:0]   rs2_nums_i,
    output logic [`IQ_DEPTH-1:0]       busy1_o,
    output logic [`IQ_DEPTH-1:0]       busy2_o
);

    logic [`PRF_DEPTH-1:0] busy_q;
    logic [`PRF_DEPTH-1:0] busy_d;

    always_comb begin
        busy_d = busy_q;
        if (set_busy0_i) begin
            busy_d[set_num0_i] = 1'b1;
        end
        if (set_busy1_i) begin
            busy_d[set_num1_i] = 1'b1;
        end
        // writeback wins over a set of the same number
        if (clr_busy_i) begin
            busy_d[clr_num_i] = 1'b0;
        end
        busy_d[0] = 1'b0;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= '0;
        end else if (flush_i) begin
            busy_q <= '0;
        end else begin
            busy_q <= busy_d;
        end
    end

    // lookup for both sources of every queue entry
    always_comb begin
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            busy1_o[i] = busy_q[rs1_nums_i[i]];
            busy2_o[i] = busy_q[rs2_nums_i[i]];
        end
    end

endmodule

`default_nettype wire

//--- issue_queue.sv
`default_nettype none

`include "backend_defines.svh"

module issue_queue import backend_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       flush_i,
    input  logic                       enq_valid0_i,
    input  logic                       enq_valid1_i,
    input  uop_t                       enq_uop0_i,
    input  uop_t                       enq_uop1_i,
    input  logic [`IQ_DEPTH-1:0]       busy1_i,
    input  logic [`IQ_DEPTH-1:0]       busy2_i,
    output prf_num_t [`IQ_DEPTH-1:0]   rs1_nums_o,
    output prf_num_t [`IQ_DEPTH-1:0]   rs2_nums_o,
    output logic                       issue_valid_o,
    output uop_t                       issue_uop_o,
    output logic                       ready_o
);

    localparam int CNT_W = $clog2(`IQ_DEPTH + 1);
    localparam int IDX_W = $clog2(`IQ_DEPTH);
    // room for two staged ops plus two new ones
    localparam int FREE_MIN = 4;

    // entry 0 is the oldest and valid entries sit below count_q
    uop_t             entry_q [`IQ_DEPTH];
    uop_t             entry_d [`IQ_DEPTH];
    logic [CNT_W-1:0] count_q;
    logic [CNT_W-1:0] count_d;
    logic [CNT_W-1:0] tail0;
    logic [CNT_W-1:0] tail1;
    logic [`IQ_DEPTH-1:0] entry_rdy;
    logic [IDX_W-1:0] sel_idx;

    always_comb begin
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            rs1_nums_o[i] = entry_q[i].prs1;
            rs2_nums_o[i] = src2_prs2(entry_q[i].src2);
        end
    end

    always_comb begin
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            entry_rdy[i] = (CNT_W'(i) < count_q) && !busy1_i[i]
                           && (entry_q[i].is_imm || !busy2_i[i]);
        end
    end

    // lowest ready index is the oldest
    always_comb begin
        sel_idx = '0;
        for (int i = `IQ_DEPTH - 1; i >= 0; i--) begin
            if (entry_rdy[i]) begin
                sel_idx = IDX_W'(i);
            end
        end
    end

    assign issue_valid_o = |entry_rdy;
    assign issue_uop_o   = entry_q[sel_idx];

    always_comb begin
        tail0   = count_q - CNT_W'(issue_valid_o);
        tail1   = tail0 + CNT_W'(enq_valid0_i);
        count_d = tail1 + CNT_W'(enq_valid1_i);
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            entry_d[i] = entry_q[i];
        end
        // compact over the issued entry
        if (issue_valid_o) begin
            for (int i = 0; i < `IQ_DEPTH - 1; i++) begin
                if (IDX_W'(i) >= sel_idx) begin
                    entry_d[i] = entry_q[i + 1];
                end
            end
        end
        // slot 0 lands ahead of slot 1
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            if (enq_valid0_i && (CNT_W'(i) == tail0)) begin
                entry_d[i] = enq_uop0_i;
            end
            if (enq_valid1_i && (CNT_W'(i) == tail1)) begin
                entry_d[i] = enq_uop1_i;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (flush_i) begin
            count_q <= '0;
        end else begin
            count_q <= count_d;
        end
    end

    always_ff @(posedge clk) begin
        entry_q <= entry_d;
    end

    assign ready_o = (count_q <= CNT_W'(`IQ_DEPTH - FREE_MIN));

endmodule

`default_nettype wire

//--- prf.sv
`default_nettype none

`include "backend_defines.svh"

module prf (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic [`PRF_NUM_W-1:0]  raddr1_i,
    input  logic [`PRF_NUM_W-1:0]  raddr2_i,
    input  logic                   we_i,
    input  logic [`PRF_NUM_W-1:0]  waddr_i,
    input  logic [`DATA_W-1:0]     wdata_i,
    output logic [`DATA_W-1:0]     rdata1_o,
    output logic [`DATA_W-1:0]     rdata2_o
);

    logic [`DATA_W-1:0] regs_q [`PRF_DEPTH];

    // unwritten registers read zero after reset
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `PRF_DEPTH; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // p0 is hardwired to zero
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs_q[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs_q[raddr2_i];

endmodule

`default_nettype wire

//--- alu_exec.sv
`default_nettype none

`include "backend_defines.svh"

module alu_exec import backend_pkg::*; (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic                issue_valid_i,
    input  uop_t                issue_uop_i,
    input  logic [`DATA_W-1:0]  rdata1_i,
    input  logic [`DATA_W-1:0]  rdata2_i,
    output prf_num_t            raddr1_o,
    output prf_num_t            raddr2_o,
    output logic                wb_valid_o,
    output prf_num_t            wb_prd_o,
    output logic [`DATA_W-1:0]  wb_data_o
);

    localparam int SHAMT_W = $clog2(`DATA_W);

    logic               rf_valid_q;
    uop_t               rf_uop_q;
    logic               ex_valid_q;
    alu_op_e            ex_op_q;
    prf_num_t           ex_prd_q;
    logic [`DATA_W-1:0] ex_op1_q;
    logic [`DATA_W-1:0] ex_op2_q;
    logic [`DATA_W-1:0] imm_ext;
    logic [`DATA_W-1:0] alu_res;
    logic [`DATA_W-1:0] wb_data_q;
    prf_num_t           wb_prd_q;
    logic               wb_valid_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rf_valid_q <= 1'b0;
            ex_valid_q <= 1'b0;
            wb_valid_q <= 1'b0;
        end else if (flush_i) begin
            rf_valid_q <= 1'b0;
            ex_valid_q <= 1'b0;
            wb_valid_q <= 1'b0;
        end else begin
            rf_valid_q <= issue_valid_i;
            ex_valid_q <= rf_valid_q;
            wb_valid_q <= ex_valid_q;
        end
    end

    // register file read stage
    assign raddr1_o = rf_uop_q.prs1;
    assign raddr2_o = src2_prs2(rf_uop_q.src2);
    assign imm_ext  = {{(`DATA_W - `IMM_W){rf_uop_q.src2.imm[`IMM_W-1]}}, rf_uop_q.src2.imm};

    always_comb begin
        case (ex_op_q)
            op_add:  alu_res = ex_op1_q + ex_op2_q;
            op_sub:  alu_res = ex_op1_q - ex_op2_q;
            op_and:  alu_res = ex_op1_q & ex_op2_q;
            op_or:   alu_res = ex_op1_q | ex_op2_q;
            op_xor:  alu_res = ex_op1_q ^ ex_op2_q;
            op_slt:  alu_res = {{(`DATA_W - 1){1'b0}}, $signed(ex_op1_q) < $signed(ex_op2_q)};
            op_sll:  alu_res = ex_op1_q << ex_op2_q[SHAMT_W-1:0];
            op_srl:  alu_res = ex_op1_q >> ex_op2_q[SHAMT_W-1:0];
            default: alu_res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        rf_uop_q  <= issue_uop_i;
        ex_op_q   <= rf_uop_q.op;
        ex_prd_q  <= rf_uop_q.prd;
        ex_op1_q  <= rdata1_i;
        ex_op2_q  <= rf_uop_q.is_imm ? imm_ext : rdata2_i;
        wb_prd_q  <= ex_prd_q;
        wb_data_q <= alu_res;
    end

    assign wb_valid_o = wb_valid_q;
    assign wb_prd_o   = wb_prd_q;
    assign wb_data_o  = wb_data_q;

endmodule

`default_nettype wire

//--- alu_backend.sv
`default_nettype none

`include "backend_defines.svh"

module alu_backend import backend_pkg::*; (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic                disp_valid0_i,
    input  logic                disp_valid1_i,
    input  uop_t                disp_uop0_i,
    input  uop_t                disp_uop1_i,
    output logic                disp_ready_o,
    output logic                wb_valid_o,
    output prf_num_t            wb_prd_o,
    output logic [`DATA_W-1:0]  wb_data_o
);

    logic                     stg_valid0;
    logic                     stg_valid1;
    uop_t                     stg_uop0;
    uop_t                     stg_uop1;
    logic                     set_busy0;
    logic                     set_busy1;
    prf_num_t                 set_num0;
    prf_num_t                 set_num1;
    prf_num_t [`IQ_DEPTH-1:0] rs1_nums;
    prf_num_t [`IQ_DEPTH-1:0] rs2_nums;
    logic [`IQ_DEPTH-1:0]     busy1;
    logic [`IQ_DEPTH-1:0]     busy2;
    logic                     issue_valid;
    uop_t                     issue_uop;
    prf_num_t                 raddr1;
    prf_num_t                 raddr2;
    logic [`DATA_W-1:0]       rdata1;
    logic [`DATA_W-1:0]       rdata2;

    dispatch_stage u_dispatch_stage (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .valid0_i     (disp_valid0_i),
        .valid1_i     (disp_valid1_i),
        .uop0_i       (disp_uop0_i),
        .uop1_i       (disp_uop1_i),
        .ready_i      (disp_ready_o),
        .enq_valid0_o (stg_valid0),
        .enq_valid1_o (stg_valid1),
        .enq_uop0_o   (stg_uop0),
        .enq_uop1_o   (stg_uop1),
        .set_busy0_o  (set_busy0),
        .set_busy1_o  (set_busy1),
        .set_num0_o   (set_num0),
        .set_num1_o   (set_num1)
    );

    // writeback clears busy at the edge that writes the register file
    scoreboard u_scoreboard (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .set_busy0_i (set_busy0),
        .set_busy1_i (set_busy1),
        .set_num0_i  (set_num0),
        .set_num1_i  (set_num1),
        .clr_busy_i  (wb_valid_o),
        .clr_num_i   (wb_prd_o),
        .rs1_nums_i  (rs1_nums),
        .rs2_nums_i  (rs2_nums),
        .busy1_o     (busy1),
        .busy2_o     (busy2)
    );

    issue_queue u_issue_queue (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .enq_valid0_i  (stg_valid0),
        .enq_valid1_i  (stg_valid1),
        .enq_uop0_i    (stg_uop0),
        .enq_uop1_i    (stg_uop1),
        .busy1_i       (busy1),
        .busy2_i       (busy2),
        .rs1_nums_o    (rs1_nums),
        .rs2_nums_o    (rs2_nums),
        .issue_valid_o (issue_valid),
        .issue_uop_o   (issue_uop),
        .ready_o       (disp_ready_o)
    );

    prf u_prf (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .raddr1_i (raddr1),
        .raddr2_i (raddr2),
        .we_i     (wb_valid_o),
        .waddr_i  (wb_prd_o),
        .wdata_i  (wb_data_o),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

    alu_exec u_alu_exec (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .issue_valid_i (issue_valid),
        .issue_uop_i   (issue_uop),
        .rdata1_i      (rdata1),
        .rdata2_i      (rdata2),
        .raddr1_o      (raddr1),
        .raddr2_o      (raddr2),
        .wb_valid_o    (wb_valid_o),
        .wb_prd_o      (wb_prd_o),
        .wb_data_o     (wb_data_o)
    );

endmodule

`default_nettype wire

//--- tb_alu_backend.sv
`default_nettype none

`include "backend_defines.svh"

module tb_alu_backend import backend_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RST_CYCLES  = 8;
    localparam int ROW_CYCLES  = 20;
    localparam int MIN_FILL    = 5;
    localparam int FLUSHED_OPS = 4;

    typedef struct packed {
        logic     v;
        alu_op_e  op;
        logic     is_imm;
        prf_num_t rs1;
        prf_num_t rs2;
        prf_num_t rd;
    } slot_t;

    typedef struct packed {
        logic  flush;
        logic  drain;
        slot_t s0;
        slot_t s1;
    } row_t;

    logic               clk = 1'b0;
    logic               rst_n_i;
    logic               flush_i;
    logic               disp_valid0_i;
    logic               disp_valid1_i;
    uop_t               disp_uop0_i;
    uop_t               disp_uop1_i;
    logic               disp_ready_o;
    logic               wb_valid_o;
    prf_num_t           wb_prd_o;
    logic [`DATA_W-1:0] wb_data_o;

    row_t               rows[$];
    logic [15:0]        lfsr_q;
    logic [`DATA_W-1:0] model_rf [`PRF_DEPTH];
    logic [`DATA_W-1:0] expect_val [`PRF_DEPTH];
    logic               used [`PRF_DEPTH];
    logic               pending [`PRF_DEPTH];
    logic               cancelled [`PRF_DEPTH];
    prf_num_t           src1_of [`PRF_DEPTH];
    prf_num_t           src2_of [`PRF_DEPTH];
    int                 wb_count [`PRF_DEPTH];
    int                 wb_order [`PRF_DEPTH];
    int                 wb_seq;
    int                 outstanding;
    int                 cancel_cnt;
    logic               ready_low_seen;

    alu_backend u_alu_backend (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .disp_valid0_i (disp_valid0_i),
        .disp_valid1_i (disp_valid1_i),
        .disp_uop0_i   (disp_uop0_i),
        .disp_uop1_i   (disp_uop1_i),
        .disp_ready_o  (disp_ready_o),
        .wb_valid_o    (wb_valid_o),
        .wb_prd_o      (wb_prd_o),
        .wb_data_o     (wb_data_o)
    );

    always #20 clk = ~clk;

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERROR at %0d ns: %s, got 0x%08h, expected 0x%08h",
                     $time, what, actual, expected);
            $display("test failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // galois form with taps at 16 14 13 and 11
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_q[0];
        lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
        return b;
    endfunction

    function automatic logic [15:0] random_bits(input int n);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[14:0], lfsr_bit()};
        end
        return r;
    endfunction

    function automatic logic [`DATA_W-1:0] model_alu(alu_op_e op, logic [`DATA_W-1:0] a,
                                                     logic [`DATA_W-1:0] b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_slt:  return ($signed(a) < $signed(b)) ? `DATA_W'(1) : '0;
            op_sll:  return a << b[4:0];
            op_srl:  return a >> b[4:0];
            default: return '0;
        endcase
    endfunction

    function automatic slot_t imm_op(alu_op_e op, int rs1, int rd);
        slot_t s;
        s = '0;
        s.v = 1'b1;
        s.op = op;
        s.is_imm = 1'b1;
        s.rs1 = prf_num_t'(rs1);
        s.rd = prf_num_t'(rd);
        return s;
    endfunction

    function automatic slot_t reg_op(alu_op_e op, int rs1, int rs2, int rd);
        slot_t s;
        s = imm_op(op, rs1, rd);
        s.is_imm = 1'b0;
        s.rs2 = prf_num_t'(rs2);
        return s;
    endfunction

    task automatic add_row(input logic drain, input slot_t s0, input slot_t s1);
        row_t r;
        r.flush = 1'b0;
        r.drain = drain;
        r.s0 = s0;
        r.s1 = s1;
        rows.push_back(r);
    endtask

    // a drain row waits for an empty backend before slot 0 and slot 1 go out
    // slot arguments are op, source 1, source 2 for register ops, destination
    task automatic load_table();
        row_t fl;
        add_row(1'b0, imm_op(op_add, 0, 1), imm_op(op_sub, 0, 2));
        add_row(1'b0, imm_op(op_and, 0, 3), imm_op(op_or, 0, 4));
        add_row(1'b0, imm_op(op_xor, 0, 5), imm_op(op_slt, 0, 6));
        add_row(1'b0, imm_op(op_sll, 0, 7), imm_op(op_srl, 0, 8));
        // register chain
        add_row(1'b0, reg_op(op_add, 1, 4, 9), reg_op(op_xor, 9, 5, 10));
        add_row(1'b0, reg_op(op_sub, 10, 2, 11), reg_op(op_slt, 11, 1, 12));
        add_row(1'b0, imm_op(op_sll, 11, 13), reg_op(op_srl, 13, 6, 14));
        add_row(1'b0, reg_op(op_and, 14, 9, 15), reg_op(op_or, 15, 10, 16));
        // p19 blocked behind p18 while p20 is free to pass it
        add_row(1'b0, imm_op(op_add, 0, 17), reg_op(op_add, 17, 17, 18));
        add_row(1'b0, reg_op(op_xor, 18, 17, 19), imm_op(op_or, 0, 20));
        // long chain to fill the queue
        add_row(1'b0, imm_op(op_add, 20, 21), imm_op(op_add, 21, 22));
        add_row(1'b0, reg_op(op_add, 22, 21, 23), imm_op(op_sub, 23, 24));
        add_row(1'b0, reg_op(op_xor, 24, 23, 25), imm_op(op_add, 25, 26));
        add_row(1'b0, reg_op(op_sub, 26, 24, 27), imm_op(op_or, 27, 28));
        add_row(1'b0, reg_op(op_add, 28, 28, 29), imm_op(op_srl, 29, 30));
        add_row(1'b0, reg_op(op_and, 30, 29, 31), imm_op(op_add, 31, 32));
        // chain killed by flush and then readers of its destinations
        add_row(1'b1, imm_op(op_add, 32, 33), reg_op(op_add, 33, 33, 34));
        add_row(1'b0, reg_op(op_xor, 34, 33, 35), imm_op(op_add, 35, 36));
        fl = '0;
        fl.flush = 1'b1;
        rows.push_back(fl);
        add_row(1'b0, reg_op(op_add, 33, 34, 37), imm_op(op_or, 36, 38));
        add_row(1'b0, reg_op(op_sub, 35, 1, 39), imm_op(op_xor, 0, 40));
    endtask

    // reference model runs in program order at dispatch time
    task automatic prepare_uop(input slot_t s, output uop_t u);
        logic [`DATA_W-1:0] a;
        logic [`DATA_W-1:0] b;
        logic [15:0]        imm;
        u = '0;
        if (s.v) begin
            u.op = s.op;
            u.is_imm = s.is_imm;
            u.prs1 = s.rs1;
            u.prd = s.rd;
            a = model_rf[s.rs1];
            if (s.is_imm) begin
                imm = random_bits(16);
                u.src2.imm = imm;
                b = {{(`DATA_W - 16){imm[15]}}, imm};
            end else begin
                u.src2.prs2_ext = 16'(s.rs2);
                b = model_rf[s.rs2];
            end
            expect_val[s.rd] = model_alu(s.op, a, b);
            model_rf[s.rd] = expect_val[s.rd];
            used[s.rd] = 1'b1;
            pending[s.rd] = 1'b1;
            src1_of[s.rd] = s.rs1;
            src2_of[s.rd] = s.is_imm ? '0 : s.rs2;
            outstanding++;
        end
    endtask

    task automatic wait_drain();
        while (outstanding != 0) begin
            @(negedge clk);
        end
    endtask

    // flushed destinations were never written and read zero
    task automatic cancel_pending();
        for (int p = 1; p < `PRF_DEPTH; p++) begin
            if (pending[p]) begin
                pending[p] = 1'b0;
                cancelled[p] = 1'b1;
                model_rf[p] = '0;
                outstanding--;
                cancel_cnt++;
            end
        end
    endtask

    always @(negedge clk) begin : monitor
        int   idx;
        logic src_ok;
        if (rst_n_i && wb_valid_o) begin
            idx = int'(wb_prd_o);
            check_value(32'(cancelled[idx]), 32'd0, $sformatf("writeback of flushed p%0d", idx));
            check_value(32'(pending[idx]), 32'd1, $sformatf("unexpected writeback of p%0d", idx));
            check_value(wb_data_o, expect_val[idx], $sformatf("wb_data_o for p%0d", idx));
            src_ok = (src1_of[idx] == '0) || (wb_count[src1_of[idx]] == 1)
                     || cancelled[src1_of[idx]];
            check_value(32'(src_ok), 32'd1, $sformatf("p%0d ahead of its source 1", idx));
            src_ok = (src2_of[idx] == '0) || (wb_count[src2_of[idx]] == 1)
                     || cancelled[src2_of[idx]];
            check_value(32'(src_ok), 32'd1, $sformatf("p%0d ahead of its source 2", idx));
            wb_count[idx]++;
            wb_order[idx] = wb_seq;
            wb_seq++;
            pending[idx] = 1'b0;
            outstanding--;
        end
        // a low ready level means at least five queue entries are in use
        if (rst_n_i && !disp_ready_o) begin
            ready_low_seen = 1'b1;
            check_value(32'(outstanding >= MIN_FILL), 32'd1, "disp_ready_o low too early");
        end
    end

    initial begin : watchdog
        int limit;
        @(posedge rst_n_i);
        limit = rows.size() * ROW_CYCLES;
        repeat (limit) @(posedge clk);
        $display("timeout: the run did not finish within %0d clock cycles", limit);
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

    initial begin : driver
        row_t r;
        uop_t u0;
        uop_t u1;
        int   gap;
        rst_n_i = 1'b0;
        flush_i = 1'b0;
        disp_valid0_i = 1'b0;
        disp_valid1_i = 1'b0;
        disp_uop0_i = '0;
        disp_uop1_i = '0;
        lfsr_q = 16'd98;
        wb_seq = 0;
        outstanding = 0;
        cancel_cnt = 0;
        ready_low_seen = 1'b0;
        for (int p = 0; p < `PRF_DEPTH; p++) begin
            model_rf[p] = '0;
            expect_val[p] = '0;
            used[p] = 1'b0;
            pending[p] = 1'b0;
            cancelled[p] = 1'b0;
            src1_of[p] = '0;
            src2_of[p] = '0;
            wb_count[p] = 0;
            wb_order[p] = 0;
        end
        load_table();
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_value(32'(wb_valid_o), 32'd0, "wb_valid_o before the first dispatch");
            check_value(32'(disp_ready_o), 32'd1, "disp_ready_o before the first dispatch");
        end
        for (int i = 0; i < rows.size(); i++) begin
            r = rows[i];
            if (r.drain) begin
                wait_drain();
            end
            if (r.flush) begin
                flush_i = 1'b1;
                @(negedge clk);
                flush_i = 1'b0;
                cancel_pending();
            end else begin
                gap = int'(random_bits(1));
                repeat (gap) @(negedge clk);
                while (!disp_ready_o) begin
                    @(negedge clk);
                end
                prepare_uop(r.s0, u0);
                prepare_uop(r.s1, u1);
                disp_uop0_i = u0;
                disp_uop1_i = u1;
                disp_valid0_i = r.s0.v;
                disp_valid1_i = r.s1.v;
                @(negedge clk);
                disp_valid0_i = 1'b0;
                disp_valid1_i = 1'b0;
            end
        end
        wait_drain();
        for (int p = 1; p < `PRF_DEPTH; p++) begin
            if (used[p] && !cancelled[p]) begin
                check_value(32'(wb_count[p]), 32'd1, $sformatf("writebacks of p%0d", p));
            end
        end
        check_value(32'(wb_order[20] < wb_order[19]), 32'd1, "p20 passes blocked p19");
        check_value(32'(ready_low_seen), 32'd1, "disp_ready_o fell under the long chain");
        check_value(32'(cancel_cnt), 32'(FLUSHED_OPS), "ops discarded by the flush");
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+.
backend_pkg.sv
dispatch_stage.sv
scoreboard.sv
issue_queue.sv
prf.sv
alu_exec.sv
alu_backend.sv
tb_alu_backend.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
TOP       ?= tb_alu_backend
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := test passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
